/* design/hackPkg.sv */
package hackPkg;

    // Basic word and address types
    typedef logic [15:0] wordT;
    typedef logic [14:0] addrT;

    // Memory map sizes
    localparam int ramWords    = 16384;
    localparam int screenWords = 8192;
    localparam int romWords    = 32768;
    localparam int ramAddrW    = $clog2(ramWords);
    localparam int screenAddrW = $clog2(screenWords);

    localparam addrT screenBase = 15'h4000;  // First screen word
    localparam addrT kbdAddr    = 15'h6000;  // Keyboard word, read only

    localparam string romImage = "verif/program.hex";

    // ALU control bits in instruction order
    typedef struct packed {
        logic zx;  // Zero x
        logic nx;  // Negate x
        logic zy;  // Zero y
        logic ny;  // Negate y
        logic f;   // Add when set, else and
        logic no;  // Negate result
    } aluCtrlT;

    typedef struct packed {
        logic a;
        logic d;
        logic m;   // Memory write
    } destT;

    typedef struct packed {
        logic lt;
        logic eq;
        logic gt;
    } jumpT;

    typedef struct packed {
        logic        op;     // Zero marks an A-instruction
        logic [14:0] value;  // Constant loaded into A
    } aInstrT;

    typedef struct packed {
        logic [2:0] prefix;   // Top bit set marks a C-instruction
        logic       aSel;     // M instead of A as ALU y input
        aluCtrlT    aluCtrl;
        destT       dest;
        jumpT       jump;
    } cInstrT;

    // One instruction word, two views
    typedef union packed {
        aInstrT a;
        cInstrT c;
    } instrT;

    typedef struct packed {
        logic write;
        addrT addr;
        wordT data;
    } memReqT;

endpackage

/* design/hackAlu.sv */
module hackAlu
    import hackPkg::*;
(
    input  wordT    x,
    input  wordT    y,
    input  aluCtrlT ctrl,
    output wordT    out,
    output logic    zr,
    output logic    ng
);

    wordT xZero;
    wordT xPre;
    wordT yZero;
    wordT yPre;
    wordT sum;
    wordT both;
    wordT result;

    // Input conditioning
    assign xZero = ctrl.zx ? '0 : x;
    assign xPre  = ctrl.nx ? ~xZero : xZero;
    assign yZero = ctrl.zy ? '0 : y;
    assign yPre  = ctrl.ny ? ~yZero : yZero;

    // Function select
    assign sum    = xPre + yPre;            // Wraps at 16 bits
    assign both   = xPre & yPre;
    assign result = ctrl.f ? sum : both;

    assign out = ctrl.no ? ~result : result;

    // Status flags for the jump decode
    assign zr = (out == '0);
    assign ng = out[15];                    // Two's complement sign

endmodule

/* design/hackCpu.sv */
module hackCpu
    import hackPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  instrT  instr,
    input  wordT   inM,
    output memReqT memReq,
    output addrT   pc
);

    wordT aReg;
    wordT dReg;
    wordT aNext;
    wordT aluY;
    wordT aluOut;
    logic zr;
    logic ng;
    logic isC;
    logic aLoad;
    logic dLoad;
    logic pos;
    logic jumpTaken;
    addrT pcNext;

    assign isC = instr.c.prefix[2];         // Same bit as instr.a.op

    // D is always the ALU x input
    assign aluY = instr.c.aSel ? inM : aReg;

    hackAlu alu_i (
        .x    (dReg),
        .y    (aluY),
        .ctrl (instr.c.aluCtrl),
        .out  (aluOut),
        .zr   (zr),
        .ng   (ng)
    );

    // Register loads
    assign aLoad = !isC || instr.c.dest.a;
    assign dLoad = isC && instr.c.dest.d;
    assign aNext = isC ? aluOut : {1'b0, instr.a.value};

    // Jump decode against the ALU flags
    assign pos       = !(zr || ng);
    assign jumpTaken = isC && ((instr.c.jump.lt && ng) ||
                               (instr.c.jump.eq && zr) ||
                               (instr.c.jump.gt && pos));
    assign pcNext    = jumpTaken ? aReg[14:0] : pc + 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aReg <= '0;
            dReg <= '0;
            pc   <= '0;
        end else begin
            if (aLoad) begin
                aReg <= aNext;
            end
            if (dLoad) begin
                dReg <= aluOut;
            end
            pc <= pcNext;
        end
    end

    // Memory address always comes from A
    assign memReq.write = isC && instr.c.dest.m;
    assign memReq.addr  = aReg[14:0];
    assign memReq.data  = aluOut;

    // A-instructions never reach memory
    aNoWrite: assert property (
        @(posedge clk) disable iff (!arstN)
        !instr.a.op |-> !memReq.write
    ) else $error("Memory write during A-instruction at pc %h", pc);

endmodule

/* design/hackMemory.sv */
module hackMemory
    import hackPkg::*;
(
    input  logic   clk,
    input  memReqT memReq,
    input  wordT   keyboard,
    output wordT   inM
);

    wordT ram    [ramWords];
    wordT screen [screenWords];

    logic selRam;
    logic selScreen;
    logic selKbd;
    logic ramWe;
    logic screenWe;
    addrT screenOff;
    logic [ramAddrW-1:0]    ramIdx;
    logic [screenAddrW-1:0] screenIdx;

    // Map decode on the top two address bits
    assign selRam    = !memReq.addr[14];
    assign selScreen = memReq.addr[14] && !memReq.addr[13];
    assign selKbd    = memReq.addr[14] && memReq.addr[13];

    assign screenOff = memReq.addr - screenBase;
    assign ramIdx    = memReq.addr[ramAddrW-1:0];
    assign screenIdx = screenOff[screenAddrW-1:0];

    // Zero latency read
    always_comb begin
        unique case (1'b1)
            selRam:    inM = ram[ramIdx];
            selScreen: inM = screen[screenIdx];
            selKbd:    inM = keyboard;      // Live input word
            default:   inM = '0;
        endcase
    end

    // Keyboard region never written
    assign ramWe    = memReq.write && selRam;
    assign screenWe = memReq.write && selScreen;

    always_ff @(posedge clk) begin
        if (ramWe) begin
            ram[ramIdx] <= memReq.data;
        end
        if (screenWe) begin
            screen[screenIdx] <= memReq.data;
        end
    end

    // Programs only store into RAM and screen
    noKbdWrite: assert property (
        @(posedge clk)
        memReq.write |-> memReq.addr < kbdAddr
    ) else $error("Write to read-only region at %h", memReq.addr);

endmodule

/* design/instrRom.sv */
module instrRom
    import hackPkg::*;
(
    input  addrT  pc,
    output instrT instr
);

    // Stored as plain words, decoded by the CPU
    wordT rom [romWords];

    initial begin
        $readmemh(romImage, rom);           // Unlisted words stay X
    end

    // Combinational fetch, the full 15-bit PC is in range
    assign instr = rom[pc];

endmodule

/* design/hackComputer.sv */
module hackComputer
    import hackPkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  wordT   keyboard,
    output memReqT memReq,
    output addrT   pc
);

    instrT instr;
    wordT  inM;

    hackCpu cpu_i (
        .clk    (clk),
        .arstN  (arstN),
        .instr  (instr),
        .inM    (inM),
        .memReq (memReq),
        .pc     (pc)
    );

    instrRom rom_i (
        .pc    (pc),
        .instr (instr)
    );

    // Data side shares the CPU request
    hackMemory mem_i (
        .clk      (clk),
        .memReq   (memReq),
        .keyboard (keyboard),
        .inM      (inM)
    );

endmodule

/* verif/tbHackComputer.sv */
module tbHackComputer
    import hackPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int   resetCycles   = 4;
    localparam int   progCycles    = 120;       // Instructions up to the halt, rounded up
    localparam int   holdCycles    = 10;        // Time spent watching the halt loop
    localparam int   timeoutCycles = 3 * (resetCycles + progCycles + holdCycles);
    localparam addrT haltAddr      = 15'd47;    // Self-jump in program.hex
    localparam int   numTests      = 6;

    logic   clk;
    logic   arstN;
    wordT   keyboard;
    memReqT memReq;
    addrT   pc;

    int     seed;
    int     cycles;
    int     errCount;
    int     testsRun;
    int     failedTests;
    int     expCount;
    int     wrIdx;                              // Index of the next expected write
    logic   pendWrite;
    logic   halted;
    addrT   expAddr [64];
    wordT   expData [64];
    int     expTest [64];
    int     testLast [numTests];                 // Last write of each test
    int     testErr [numTests];
    string  testName [numTests];

    hackComputer dut_i (
        .clk      (clk),
        .arstN    (arstN),
        .keyboard (keyboard),
        .memReq   (memReq),
        .pc       (pc)
    );

    always #5 clk = ~clk;

    task automatic noteError(input int t);
        errCount++;
        testErr[t]++;
    endtask

    task automatic addWrite(input addrT addr, input wordT data, input int t);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expTest[expCount] = t;
        testLast[t] = expCount;
        expCount++;
    endtask

    task automatic reportTest(input int t);
        testsRun++;
        if (testErr[t] == 0) begin
            $display("Test %0d %s: ok", t + 1, testName[t]);
        end else begin
            failedTests++;
            $display("Test %0d %s: fail, %0d errors", t + 1, testName[t], testErr[t]);
        end
    endtask

    // Expected stores in program order, from the Hack instruction rules
    task automatic buildTable();
        wordT d;
        wordT a;
        wordT sum;
        wordT probe;
        d = 16'd7;
        a = 16'd5;
        addWrite(15'd5, d + a, 1);
        addWrite(15'd5, d - a, 1);
        addWrite(15'd5, a - d, 1);
        addWrite(15'd5, d & a, 1);
        addWrite(15'd5, d | a, 1);
        addWrite(15'd5, 16'd0 - 16'd1, 1);
        addWrite(15'd5, ~d, 1);
        addWrite(15'd5, 16'd0 - d, 1);
        addWrite(15'd5, d + 16'd1, 1);
        addWrite(15'd5, a - 16'd1, 1);
        sum = '0;
        addWrite(15'd21, sum, 2);
        for (int i = 10; i >= 1; i--) begin
            sum = sum + wordT'(i);              // Ends at 55
            addWrite(15'd21, sum, 2);
        end
        addWrite(15'd22, 16'd1, 2);             // Not-taken JGT marker
        addWrite(15'd24, 16'hFFFF, 2);          // Taken JLT, D holds -1
        probe = 16'h1234;
        addWrite(15'd25, probe, 3);
        addWrite(15'd25, probe + 16'd1, 3);
        addWrite(screenBase, ~probe, 4);
        addWrite(15'd26, ~probe, 4);
        addWrite(15'd27, keyboard, 4);
    endtask

    // Reset holds PC and write strobe low, also one cycle past release
    resetHold: assert property (
        @(posedge clk) (!arstN || $rose(arstN)) |-> (pc == '0 && !memReq.write)
    ) else begin
        noteError(0);
        $display("Reset check failed, pc %h write %b", $sampled(pc), $sampled(memReq.write));
    end

    writeExpected: assert property (
        @(posedge clk) disable iff (!arstN)
        memReq.write |-> wrIdx < expCount
    ) else begin
        noteError(5);
        $display("Unexpected write at %h after all %0d expected writes",
                 $sampled(memReq.addr), expCount);
    end

    writeAddr: assert property (
        @(posedge clk) disable iff (!arstN)
        memReq.write && wrIdx < expCount |-> memReq.addr == expAddr[wrIdx]
    ) else begin
        noteError(expTest[wrIdx]);
        $display("Mismatch memReq.addr write %0d expected %h got %h",
                 wrIdx, expAddr[wrIdx], $sampled(memReq.addr));
    end

    writeData: assert property (
        @(posedge clk) disable iff (!arstN)
        memReq.write && wrIdx < expCount |-> memReq.data == expData[wrIdx]
    ) else begin
        noteError(expTest[wrIdx]);
        $display("Mismatch memReq.data write %0d expected %h got %h",
                 wrIdx, expData[wrIdx], $sampled(memReq.data));
    end

    haltStay: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |-> pc == haltAddr
    ) else begin
        noteError(5);
        $display("PC left the halt address, pc %h", $sampled(pc));
    end

    haltQuiet: assert property (
        @(posedge clk) disable iff (!arstN)
        halted |-> !memReq.write
    ) else begin
        noteError(5);
        $display("Write to %h after the halt address was reached", $sampled(memReq.addr));
    end

    // Write bookkeeping away from the checking edge
    always @(negedge clk) begin
        if (pendWrite) begin
            if (wrIdx < expCount && wrIdx == testLast[expTest[wrIdx]]) begin
                reportTest(expTest[wrIdx]);
            end
            wrIdx++;
        end
        pendWrite = arstN && memReq.write;      // Commits at the next rising edge
        if (arstN && pc == haltAddr) begin
            halted = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("Timeout after %0d cycles, halt address %h not reached", cycles, haltAddr);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        seed        = 10;
        keyboard    = wordT'($random(seed));
        cycles      = 0;
        errCount    = 0;
        testsRun    = 0;
        failedTests = 0;
        expCount    = 0;
        wrIdx       = 0;
        pendWrite   = 1'b0;
        halted      = 1'b0;
        testName    = '{"reset", "alu", "jumps", "readModifyWrite", "screenKbd", "halt"};
        foreach (testErr[t]) begin
            testErr[t]  = 0;
            testLast[t] = -1;
        end
        buildTable();
        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        reportTest(0);
        while (!halted) begin
            @(negedge clk);
        end
        repeat (holdCycles) @(negedge clk);
        allWrites: assert (wrIdx == expCount) else begin
            noteError(5);
            $display("Only %0d of %0d expected writes were seen", wrIdx, expCount);
        end
        reportTest(5);
        $display("Tests run %0d, failed %0d, errors %0d", testsRun, failedTests, errCount);
        if (failedTests == 0 && errCount == 0 && testsRun == numTests) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* verif/program.hex */
// One 16-bit instruction word per line, in hex, starting at ROM address 0
// Words below 8000 load A, words from E000 up are C-instructions
0007 // D = 7
EC10
0005 // A = 5, every ALU result goes to RAM[5]
E088 // M=D+A
E4C8 // M=D-A
E1C8 // M=A-D
E008 // M=D&A
E548 // M=D|A
EE88 // M=-1
E348 // M=!D
E3C8 // M=-D
E7C8 // M=D+1
EC88 // M=A-1
000A // Loop counter D = 10
EC10
0015
EA88 // Sum RAM[21] = 0
0015 // Loop start at 17
F088 // M=D+M
E390 // D=D-1
0011
E301 // D;JGT
001A
E301 // D is zero, not taken
0016
EFC8 // Marker RAM[22] = 1
001E
EE94 // D=-1;JLT, taken
0017
EA88 // Skipped marker RAM[23]
0018 // Jump lands here
E308 // RAM[24] = D
1234
EC10
0019
E308 // RAM[25] = 1234
FDC8 // M=M+1
4000 // First screen word
E348 // M=!D
FC10 // D=M
001A
E308 // RAM[26] = screen word
6000 // Keyboard
FC10
001B
E308 // RAM[27] = keyboard
002F
EA87 // 0;JMP at 47, A holds 47

/* filelist.f */
design/hackPkg.sv
design/hackAlu.sv
design/hackCpu.sv
design/hackMemory.sv
design/instrRom.sv
design/hackComputer.sv
verif/tbHackComputer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run from the project root so the ROM image path resolves
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert -Wno-fatal --top-module tbHackComputer -f filelist.f \
    -o simHack > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simHack 2>&1 | tee sim.log
grep -qx "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }
